// File: hdl/cell_position_mem.sv
// Home and neighbor cell position storage with registered pair read
`timescale 1ns/1ps
`include "rl_defs.svh"

module cell_position_mem (
	input  logic                           clk,
	input  logic                           we,
	input  logic                           cell_sel,  // 0 home, 1 neighbor
	input  logic [`RL_CELL_ADDR_WIDTH-1:0] waddr,
	input  rl_pkg::position_t              wdata,
	input  rl_pkg::pair_id_t               pair,      // Read indices
	output rl_pkg::position_t              home_pos,
	output rl_pkg::position_t              neighbor_pos
);
	import rl_pkg::*;

	position_t home_mem [`RL_MAX_CELL_PARTICLES];
	position_t nbr_mem  [`RL_MAX_CELL_PARTICLES];

	// Load port, only used between runs
	always_ff @(posedge clk) begin
		if (we) begin
			if (cell_sel)
				nbr_mem[waddr] <= wdata;
			else
				home_mem[waddr] <= wdata;
		end
	end

	// Both cells read together, one cycle latency
	always_ff @(posedge clk) begin
		home_pos     <= home_mem[pair.home];
		neighbor_pos <= nbr_mem[pair.neighbor];
	end

endmodule

// File: hdl/cutoff_filter.sv
// Distance components, squared distance, cutoff test and segment/bin address register
`timescale 1ns/1ps
`include "rl_defs.svh"

module cutoff_filter (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	input  rl_pkg::pair_id_t      in_pair,
	input  rl_pkg::position_t     home_pos,
	input  rl_pkg::position_t     neighbor_pos,
	output rl_pkg::filter_out_t   out
);
	import rl_pkg::*;

	localparam int seg0_bits = 2 * `RL_BIN_WIDTH;   // r2 below 2^16 is segment 0
	localparam int seg_base  = seg0_bits - 1;       // Segment is msb minus this

	logic signed [`RL_DIFF_WIDTH-1:0] dx, dy, dz;
	logic signed [`RL_R2_WIDTH-1:0]   sq_x, sq_y, sq_z;
	logic [`RL_R2_WIDTH-1:0]          r2;
	logic                             keep;
	lut_addr_u                        addr;

	// Home minus neighbor, one extra bit for the sign
	assign dx = $signed({1'b0, home_pos.x}) - $signed({1'b0, neighbor_pos.x});
	assign dy = $signed({1'b0, home_pos.y}) - $signed({1'b0, neighbor_pos.y});
	assign dz = $signed({1'b0, home_pos.z}) - $signed({1'b0, neighbor_pos.z});

	assign sq_x = dx * dx;   // At most 2^30 each
	assign sq_y = dy * dy;
	assign sq_z = dz * dz;
	assign r2   = sq_x + sq_y + sq_z;   // Fits 32 bits unsigned

	assign keep = (r2 < `RL_CUTOFF_2);

	// Segment and bin from the leading one of r2
	always_comb begin
		addr.field.segment = '0;          // Segment 0 default
		addr.field.bin     = r2[seg0_bits-1 -: `RL_BIN_WIDTH];
		for (int i = seg0_bits; i < `RL_CUTOFF_BITS; i++) begin
			if (r2[i]) begin              // Highest set bit wins
				addr.field.segment = `RL_SEGMENT_WIDTH'(i - seg_base);
				addr.field.bin     = r2[i-1 -: `RL_BIN_WIDTH]; // Bits just below msb
			end
		end
	end

	always_ff @(posedge clk) begin
		out.pair <= in_pair;
		out.dx   <= dx;
		out.dy   <= dy;
		out.dz   <= dz;
		out.addr <= addr;
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= in_valid && keep;  // Rejected pairs vanish here
	end

endmodule

// File: hdl/force_lut_eval.sv
// Writable force coefficient table and force component multiply stage
`timescale 1ns/1ps
`include "rl_defs.svh"

module force_lut_eval (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              lut_we,
	input  logic [`RL_LOOKUP_ADDR_WIDTH-1:0]  lut_waddr,
	input  logic signed [`RL_COEF_WIDTH-1:0]  lut_wdata,
	input  rl_pkg::filter_out_t               in,
	output rl_pkg::force_out_t                out
);
	import rl_pkg::*;

	logic signed [`RL_COEF_WIDTH-1:0] coef_mem [`RL_LUT_DEPTH];  // 9 segments of 256 bins
	logic signed [`RL_COEF_WIDTH-1:0] coef_q;

	// Components held back to line up with the table read
	logic                             s1_valid;
	pair_id_t                         s1_pair;
	logic signed [`RL_DIFF_WIDTH-1:0] s1_dx, s1_dy, s1_dz;

	always_ff @(posedge clk) begin
		if (lut_we && lut_waddr < `RL_LUT_DEPTH)
			coef_mem[lut_waddr] <= lut_wdata;
	end

	// Stage 1 table read on the flat view
	always_ff @(posedge clk) begin
		coef_q  <= coef_mem[in.addr.flat];
		s1_pair <= in.pair;
		s1_dx   <= in.dx;
		s1_dy   <= in.dy;
		s1_dz   <= in.dz;
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= in.valid;
	end

	// Stage 2 coefficient times each component
	always_ff @(posedge clk) begin
		out.pair <= s1_pair;
		out.fx   <= coef_q * s1_dx;   // 16 by 16 signed into 32
		out.fy   <= coef_q * s1_dy;
		out.fz   <= coef_q * s1_dz;
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= s1_valid;
	end

endmodule

// File: hdl/pair_counter.sv
// Nested home and neighbor index counter with last-pair flag
`timescale 1ns/1ps
`include "rl_defs.svh"

module pair_counter (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          clear,
	input  logic                          enable,
	input  logic [`RL_CELL_ADDR_WIDTH:0]  home_count,     // 1 to 32
	input  logic [`RL_CELL_ADDR_WIDTH:0]  neighbor_count, // 1 to 32
	output rl_pkg::pair_id_t              pair,
	output logic                          last_pair
);
	import rl_pkg::*;

	logic [`RL_CELL_ADDR_WIDTH-1:0] home_idx;
	logic [`RL_CELL_ADDR_WIDTH-1:0] nbr_idx;
	logic                           last_home;
	logic                           last_nbr;

	// Compare one bit wider so a count of 32 still matches index 31
	assign last_nbr  = ({1'b0, nbr_idx} == neighbor_count - 1'b1);
	assign last_home = ({1'b0, home_idx} == home_count - 1'b1);
	assign last_pair = last_home && last_nbr; // 1 by 1 is last at once

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			home_idx <= '0;
			nbr_idx  <= '0;
		end else if (enable) begin
			if (last_nbr) begin
				nbr_idx <= '0;                // Neighbor wraps
				if (last_home)
					home_idx <= '0;           // Whole walk done
				else
					home_idx <= home_idx + 1'b1;
			end else begin
				nbr_idx <= nbr_idx + 1'b1;    // Neighbor walks fastest
			end
		end
	end

	assign pair.home     = home_idx;
	assign pair.neighbor = nbr_idx;

endmodule

// File: hdl/rl_controller.sv
// Run sequencing FSM for idle, run, drain and done
`timescale 1ns/1ps

module rl_controller (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic last_pair,     // Counter sits on the final pair
	input  logic pipe_busy,     // Any visible stage valid
	output logic pair_en,
	output logic counter_clear,
	output logic done
);
	import rl_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic        busy_q;        // pipe_busy one cycle back
	logic        accept_start;

	// Start only counts from idle or done
	assign accept_start = start && (state == st_idle || state == st_done);

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= st_idle;
			busy_q <= 1'b0;
		end else begin
			state  <= next_state;
			busy_q <= pipe_busy;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (accept_start)
					next_state = st_run;   // First issue next cycle
			end
			st_run: begin
				if (last_pair)
					next_state = st_drain; // Final pair goes out this cycle
			end
			st_drain: begin
				// Table read stage inside the lut unit is not in pipe_busy
				// Two quiet cycles in a row mean nothing is left in flight
				if (!pipe_busy && !busy_q)
					next_state = st_done;
			end
			st_done: begin
				if (accept_start)
					next_state = st_run;
			end
			default: next_state = st_idle;
		endcase
	end

	assign pair_en       = (state == st_run);  // One pair per cycle
	assign counter_clear = accept_start;       // Indices back to zero
	assign done          = (state == st_done); // Level until next start

endmodule

// File: hdl/rl_pkg.sv
// Position, pair id, filter and force output structs, lookup address union, controller states
`include "rl_defs.svh"

package rl_pkg;

	typedef struct packed {
		logic [`RL_POS_WIDTH-1:0] x;
		logic [`RL_POS_WIDTH-1:0] y;
		logic [`RL_POS_WIDTH-1:0] z;
	} position_t;

	// Particle ids of one pair, also the ids on the output
	typedef struct packed {
		logic [`RL_CELL_ADDR_WIDTH-1:0] home;
		logic [`RL_CELL_ADDR_WIDTH-1:0] neighbor;
	} pair_id_t;

	typedef struct packed {
		logic [`RL_SEGMENT_WIDTH-1:0] segment;
		logic [`RL_BIN_WIDTH-1:0]     bin;
	} lut_field_t;

	// Filter builds segment and bin, table indexes the flat word
	typedef union packed {
		lut_field_t                       field;
		logic [`RL_LOOKUP_ADDR_WIDTH-1:0] flat;
	} lut_addr_u;

	typedef struct packed {
		logic                             valid;
		pair_id_t                         pair;
		logic signed [`RL_DIFF_WIDTH-1:0] dx;
		logic signed [`RL_DIFF_WIDTH-1:0] dy;
		logic signed [`RL_DIFF_WIDTH-1:0] dz;
		lut_addr_u                        addr;
	} filter_out_t;

	typedef struct packed {
		logic                              valid;
		pair_id_t                          pair;
		logic signed [`RL_FORCE_WIDTH-1:0] fx;
		logic signed [`RL_FORCE_WIDTH-1:0] fy;
		logic signed [`RL_FORCE_WIDTH-1:0] fz;
	} force_out_t;

	typedef enum logic [1:0] {st_idle, st_run, st_drain, st_done} ctrl_state_t;

endpackage

// File: hdl/rl_top.sv
// Range-limited force top with controller, pair counter, position memory and force pipeline
`timescale 1ns/1ps
`include "rl_defs.svh"

module rl_top (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              start,           // Pulse
	input  logic                              pos_we,
	input  logic                              pos_cell,        // 0 home, 1 neighbor
	input  logic [`RL_CELL_ADDR_WIDTH-1:0]    pos_addr,
	input  rl_pkg::position_t                 pos_data,
	input  logic                              lut_we,
	input  logic [`RL_LOOKUP_ADDR_WIDTH-1:0]  lut_addr,
	input  logic signed [`RL_COEF_WIDTH-1:0]  lut_data,
	input  logic [`RL_CELL_ADDR_WIDTH:0]      home_count,      // Stable during a run
	input  logic [`RL_CELL_ADDR_WIDTH:0]      neighbor_count,
	output rl_pkg::force_out_t                force_out,
	output logic                              done
);
	import rl_pkg::*;

	logic        pair_en;
	logic        counter_clear;
	logic        last_pair;
	logic        pipe_busy;
	pair_id_t    pair;
	position_t   home_pos;
	position_t   neighbor_pos;
	logic        mem_valid;      // Issue valid matched to memory read
	pair_id_t    mem_pair;
	filter_out_t filt;

	rl_controller u_controller (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.last_pair     (last_pair),
		.pipe_busy     (pipe_busy),
		.pair_en       (pair_en),
		.counter_clear (counter_clear),
		.done          (done)
	);

	pair_counter u_pair_counter (
		.clk            (clk),
		.reset          (reset),
		.clear          (counter_clear),
		.enable         (pair_en),
		.home_count     (home_count),
		.neighbor_count (neighbor_count),
		.pair           (pair),
		.last_pair      (last_pair)
	);

	cell_position_mem u_position_mem (
		.clk          (clk),
		.we           (pos_we),
		.cell_sel     (pos_cell),
		.waddr        (pos_addr),
		.wdata        (pos_data),
		.pair         (pair),
		.home_pos     (home_pos),
		.neighbor_pos (neighbor_pos)
	);

	// Valid and ids ride alongside the position read
	always_ff @(posedge clk) begin
		mem_pair <= pair;
		if (reset)
			mem_valid <= 1'b0;
		else
			mem_valid <= pair_en;
	end

	cutoff_filter u_cutoff_filter (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (mem_valid),
		.in_pair      (mem_pair),
		.home_pos     (home_pos),
		.neighbor_pos (neighbor_pos),
		.out          (filt)
	);

	force_lut_eval u_force_lut (
		.clk       (clk),
		.reset     (reset),
		.lut_we    (lut_we),
		.lut_waddr (lut_addr),
		.lut_wdata (lut_data),
		.in        (filt),
		.out       (force_out)
	);

	assign pipe_busy = mem_valid | filt.valid | force_out.valid;  // Drain watch

endmodule

// File: include/rl_defs.svh
// Width, cell capacity, cutoff and lookup table geometry macros
`ifndef RL_DEFS_SVH
`define RL_DEFS_SVH

// Particle position, unsigned per coordinate
`define RL_POS_WIDTH          15
`define RL_DIFF_WIDTH         (`RL_POS_WIDTH + 1)   // Signed difference

// Cell storage
`define RL_CELL_ADDR_WIDTH    5
`define RL_MAX_CELL_PARTICLES 32

// Cutoff on squared distance, exclusive
`define RL_R2_WIDTH           32
`define RL_CUTOFF_BITS        24
`define RL_CUTOFF_2           (32'd1 << `RL_CUTOFF_BITS)

// Force table geometry
`define RL_SEGMENT_WIDTH      4
`define RL_SEGMENT_NUM        9
`define RL_BIN_WIDTH          8
`define RL_LOOKUP_ADDR_WIDTH  (`RL_SEGMENT_WIDTH + `RL_BIN_WIDTH)
`define RL_LUT_DEPTH          (`RL_SEGMENT_NUM << `RL_BIN_WIDTH)

// Arithmetic
`define RL_COEF_WIDTH         16    // Signed coefficient
`define RL_FORCE_WIDTH        32

// Issue to force_out
`define RL_PIPE_LATENCY       4

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the range-limited force testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module rl_top_tb -Mdir obj_dir \
	&& ./obj_dir/Vrl_top_tb > sim.log 2>&1 \
	|| { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: sim/rl_top_tb.sv
// Testbench for rl_top with case table, LFSR loads, pair reference model, monitor and watchdog
`timescale 1ns/1ps
`include "rl_defs.svh"

module rl_top_tb;
	import rl_pkg::*;

	localparam int num_cases = 8;
	localparam int lut_depth = `RL_LUT_DEPTH;
	localparam int cell_size = `RL_MAX_CELL_PARTICLES;
	localparam logic [1:0] sp_tight = 2'd0;   // 9-bit spread keeps every pair inside cutoff
	localparam logic [1:0] sp_mixed = 2'd1;   // 12-bit spread straddling the cutoff
	localparam logic [1:0] sp_wide  = 2'd2;   // Whole coordinate range

	typedef struct packed {
		logic [5:0] home_n;
		logic [5:0] nbr_n;
		logic [1:0] spread;
		logic       mid_start;   // Extra start pulse while busy
		logic       all_kept;    // Every pair must pass the cutoff
	} case_t;

	typedef struct packed {
		int                 cycle;   // Cycle count where the output must show
		pair_id_t           pair;
		logic signed [31:0] fx;
		logic signed [31:0] fy;
		logic signed [31:0] fz;
	} expect_t;

	case_t cases [num_cases] = '{
		'{6'd1,  6'd1,  sp_tight, 1'b0, 1'b1},   // Single pair
		'{6'd4,  6'd7,  sp_tight, 1'b0, 1'b1},
		'{6'd32, 6'd32, sp_tight, 1'b0, 1'b1},   // Full cells give a dense stream
		'{6'd12, 6'd20, sp_mixed, 1'b1, 1'b0},
		'{6'd32, 6'd32, sp_mixed, 1'b0, 1'b0},
		'{6'd9,  6'd5,  sp_wide,  1'b0, 1'b0},   // Mostly rejected
		'{6'd32, 6'd1,  sp_mixed, 1'b1, 1'b0},
		'{6'd1,  6'd32, sp_tight, 1'b1, 1'b1}
	};

	logic                             clk;
	logic                             reset;
	logic                             start;
	logic                             pos_we;
	logic                             pos_cell;
	logic [`RL_CELL_ADDR_WIDTH-1:0]   pos_addr;
	position_t                        pos_data;
	logic                             lut_we;
	logic [`RL_LOOKUP_ADDR_WIDTH-1:0] lut_addr;
	logic signed [`RL_COEF_WIDTH-1:0] lut_data;
	logic [`RL_CELL_ADDR_WIDTH:0]     home_count;
	logic [`RL_CELL_ADDR_WIDTH:0]     neighbor_count;
	force_out_t                       force_out;
	logic                             done;

	position_t                        home_m [cell_size];   // Mirror of position memory
	position_t                        nbr_m  [cell_size];
	logic signed [`RL_COEF_WIDTH-1:0] coef_m [lut_depth];   // Mirror of coefficient table
	expect_t                          exp_q [$];
	logic [31:0]                      lfsr;
	int                               cycle;
	int                               errors;
	int                               outputs;   // Valid outputs in the current case
	int                               total_outputs;
	int                               seg0_hits;
	int                               seg_hi_hits;

	rl_top dut (
		.clk(clk), .reset(reset), .start(start),
		.pos_we(pos_we), .pos_cell(pos_cell), .pos_addr(pos_addr), .pos_data(pos_data),
		.lut_we(lut_we), .lut_addr(lut_addr), .lut_data(lut_data),
		.home_count(home_count), .neighbor_count(neighbor_count),
		.force_out(force_out), .done(done)
	);

	always #10 clk = ~clk;
	always @(posedge clk) cycle <= cycle + 1;

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic logic [`RL_POS_WIDTH-1:0] place_coord(input logic [1:0] spread);
		if (spread == sp_tight) return 15'd12000 + 15'(take_bits(9));
		if (spread == sp_mixed) return 15'd12000 + 15'(take_bits(12));
		return 15'(take_bits(15));
	endfunction

	task automatic load_lut();
		for (int a = 0; a < lut_depth; a++) begin
			@(negedge clk);
			lut_we    = 1'b1;
			lut_addr  = 12'(a);
			lut_data  = 16'(take_bits(16));   // Signed values of both polarities
			coef_m[a] = lut_data;
		end
		@(negedge clk);
		lut_we = 1'b0;
	endtask

	// All 64 slots rewritten while done holds from the last run
	task automatic load_positions(input logic [1:0] spread, input logic hold_done);
		for (int k = 0; k < 2 * cell_size; k++) begin
			@(negedge clk);
			if (hold_done && !done) begin
				$display("error at %0t: done dropped while loading positions", $time);
				errors++;
			end
			pos_we     = 1'b1;
			pos_cell   = (k >= cell_size);
			pos_addr   = 5'(k);
			pos_data.x = place_coord(spread);
			pos_data.y = place_coord(spread);
			pos_data.z = place_coord(spread);
			if (pos_cell) nbr_m[pos_addr] = pos_data;
			else home_m[pos_addr] = pos_data;
		end
		@(negedge clk);
		pos_we = 1'b0;
	endtask

	// Kept pairs in issue order with neighbor fastest and forces from segment and bin rules
	task automatic build_expected(input int h_n, input int n_n, input int first, output int kept);
		int      dx, dy, dz, m, seg, bin, idx;
		longint  r2;
		expect_t e;
		kept = 0;
		idx  = 0;
		for (int h = 0; h < h_n; h++) begin
			for (int n = 0; n < n_n; n++) begin
				dx = int'(home_m[h].x) - int'(nbr_m[n].x);
				dy = int'(home_m[h].y) - int'(nbr_m[n].y);
				dz = int'(home_m[h].z) - int'(nbr_m[n].z);
				r2 = longint'(dx) * dx + longint'(dy) * dy + longint'(dz) * dz;
				if (r2 < (longint'(1) << 24)) begin
					if (r2 < 65536) begin
						seg = 0;
						bin = int'((r2 >> 8) & 255);
						seg0_hits++;
					end else begin
						m = 16;
						for (int b = 16; b < 24; b++) if (r2[b]) m = b;   // Leading one
						seg = m - 15;
						bin = int'((r2 >> (m - 8)) & 255);
						if (seg >= 6) seg_hi_hits++;
					end
					e.cycle         = first + idx;
					e.pair.home     = 5'(h);
					e.pair.neighbor = 5'(n);
					e.fx = int'(coef_m[seg * 256 + bin]) * dx;
					e.fy = int'(coef_m[seg * 256 + bin]) * dy;
					e.fz = int'(coef_m[seg * 256 + bin]) * dz;
					exp_q.push_back(e);
					kept++;
				end
				idx++;   // Rejected pairs still take an issue slot
			end
		end
	endtask

	// Output monitor sampling mid-cycle
	always @(negedge clk) begin
		expect_t e;
		if (!reset && force_out.valid) begin
			outputs++;
			if (exp_q.size() == 0) begin
				$display("error at %0t: unexpected output for pair %0d/%0d", $time,
					force_out.pair.home, force_out.pair.neighbor);
				errors++;
			end else begin
				e = exp_q.pop_front();
				if (cycle != e.cycle || force_out.pair != e.pair) begin
					$display("error at %0t: pair %0d/%0d at cycle %0d, expected %0d/%0d at %0d",
						$time, force_out.pair.home, force_out.pair.neighbor, cycle,
						e.pair.home, e.pair.neighbor, e.cycle);
					errors++;
				end
				if (force_out.fx != e.fx || force_out.fy != e.fy || force_out.fz != e.fz) begin
					$display("error at %0t: force %0d %0d %0d, expected %0d %0d %0d", $time,
						force_out.fx, force_out.fy, force_out.fz, e.fx, e.fy, e.fz);
					errors++;
				end
			end
		end
	end

	task automatic run_case(input int c);
		case_t tc;
		int    kept;
		int    waited;
		tc = cases[c];
		load_positions(tc.spread, c > 0);
		home_count     = tc.home_n;
		neighbor_count = tc.nbr_n;
		@(negedge clk);
		outputs = 0;
		build_expected(tc.home_n, tc.nbr_n, cycle + 5, kept);   // Issue next cycle plus 4 stages
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (done) begin
			$display("error at %0t: done still high after start in case %0d", $time, c);
			errors++;
		end
		waited = 1;
		while (!done) begin
			@(negedge clk);
			waited++;
			start = tc.mid_start && (waited == 3) && !done;   // Ignored while busy
		end
		start = 1'b0;
		@(posedge clk);
		if (exp_q.size() != 0 || outputs != kept) begin
			$display("error at %0t: case %0d gave %0d outputs, expected %0d", $time, c,
				outputs, kept);
			errors++;
		end
		exp_q.delete();
		if (tc.all_kept && outputs != int'(tc.home_n) * int'(tc.nbr_n)) begin
			$display("error at %0t: case %0d gave %0d outputs, full pair set is %0d", $time, c,
				outputs, int'(tc.home_n) * int'(tc.nbr_n));
			errors++;
		end
		repeat (5) begin
			@(negedge clk);
			if (!done) begin
				$display("error at %0t: done fell before the next start", $time);
				errors++;
			end
		end
		total_outputs += outputs;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		pos_we = 1'b0;
		pos_cell = 1'b0;
		pos_addr = '0;
		pos_data = '0;
		lut_we = 1'b0;
		lut_addr = '0;
		lut_data = '0;
		home_count = 6'd1;
		neighbor_count = 6'd1;
		lfsr = 32'h9f85;
		cycle = 0;
		errors = 0;
		outputs = 0;
		total_outputs = 0;
		seg0_hits = 0;
		seg_hi_hits = 0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		if (done || force_out.valid) begin
			$display("error at %0t: done or force_out valid high after reset", $time);
			errors++;
		end
		load_lut();
		for (int c = 0; c < num_cases; c++) run_case(c);
		if (seg0_hits == 0 || seg_hi_hits == 0) begin
			$display("stimulus never reached segment 0 or the upper segments");
			errors++;
		end
		$display("run complete: %0d errors, %0d outputs checked", errors, total_outputs);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Watchdog sized from table loads and every case's pair count
	initial begin
		longint limit;
		limit = 16 + 4 + lut_depth;
		for (int c = 0; c < num_cases; c++)
			limit += 2 * cell_size + int'(cases[c].home_n) * int'(cases[c].nbr_n) + 50;
		#(limit * 20);
		$display("watchdog expired after %0d cycles, run did not finish", limit);
		$display("TB FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
hdl/rl_pkg.sv
hdl/rl_controller.sv
hdl/pair_counter.sv
hdl/cell_position_mem.sv
hdl/cutoff_filter.sv
hdl/force_lut_eval.sv
hdl/rl_top.sv
sim/rl_top_tb.sv
